// ==== list.f ====
verilog/lc_pkg.sv
verilog/lc_issue_buffer.sv
verilog/lc_issue.sv
verilog/lc_execute.sv
verilog/lc_regfile.sv
verilog/lc_top.sv
verif/lc_asserts.sv
verif/lc_tb.sv

// ==== Bender.yml ====
package:
  name: lc_cluster

sources:
  - files:
      - verilog/lc_pkg.sv
      - verilog/lc_issue_buffer.sv
      - verilog/lc_issue.sv
      - verilog/lc_execute.sv
      - verilog/lc_regfile.sv
      - verilog/lc_top.sv
  - target: test
    files:
      - verif/lc_asserts.sv
      - verif/lc_tb.sv

// ==== verif/lc_tb.sv ====
// Needs at most 256 dispatches so tags never wrap; the model assumes x0 reads as zero
`default_nettype none

module lc_tb import lc_pkg::*; ();

	localparam int N_LOADS = 31;
	localparam int N_MIXED = 200;
	localparam int TIMEOUT = 40 * (N_LOADS + N_MIXED) + 100;

	logic CLK;
	logic rst;
	logic dispatch_valid;
	lc_entry_t dispatch;
	logic dispatch_ready;
	logic commit_valid;
	lc_commit_t commit;

	logic [63:0] model_regs [32];
	lc_commit_t expected [256];
	string test_of_tag [256];
	bit [255:0] expect_known;
	bit [255:0] seen;
	int sent;
	int done_count;
	int cycles;
	logic [31:0] rng;
	logic [7:0] tag_next;

	lc_top #(
		.DEPTH(4)
	) lc_top_inst (
		.CLK(CLK),
		.rst(rst),
		.dispatch_valid(dispatch_valid),
		.dispatch(dispatch),
		.dispatch_ready(dispatch_ready),
		.commit_valid(commit_valid),
		.commit(commit)
	);

	always #5 CLK = ~CLK;

	function automatic logic [31:0] xorshift32(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Narrow pool most of the time, so hazards are frequent
	function automatic logic [4:0] pick_reg(logic [7:0] r);
		return (r[7:6] == 2'b11) ? r[4:0] : {2'b00, r[2:0]};
	endfunction

	function automatic logic [63:0] model_result(lc_entry_t e);
		logic [63:0] a;
		logic [63:0] rb;
		logic [63:0] ib;
		a = model_regs[e.rs1];
		rb = model_regs[e.src2.reg_idx.idx];
		ib = {{52{e.src2.imm[11]}}, e.src2.imm};
		case (e.op)
			OP_SLT: return ($signed(a) < $signed(rb)) ? 64'd1 : 64'd0;
			OP_SLTU: return (a < rb) ? 64'd1 : 64'd0;
			OP_SLTI: return ($signed(a) < $signed(ib)) ? 64'd1 : 64'd0;
			OP_SLTIU: return (a < ib) ? 64'd1 : 64'd0;
			OP_XOR: return a ^ rb;
			OP_XORI: return a ^ ib;
			OP_OR: return a | rb;
			OP_ORI: return a | ib;
			OP_AND: return a & rb;
			default: return a & ib;
		endcase
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
			fail_run($sformatf("Error: %s expected %0b actual %0b", name, exp, act));
	endtask

	task automatic check_commit(input string name, input lc_commit_t exp, input lc_commit_t act);
		if (act !== exp)
			fail_run($sformatf(
				"Error: %s expected rd=%0d tag=%0d value=%h actual rd=%0d tag=%0d value=%h",
				name, exp.rd, exp.tag, exp.value, act.rd, act.tag, act.value));
	endtask

	// In-order reference, updated at the accepting edge
	task automatic record_dispatch(input lc_entry_t e, input string name);
		lc_commit_t c;
		c.rd = e.rd;
		c.tag = e.tag;
		c.value = model_result(e);
		expected[e.tag] = c;
		test_of_tag[e.tag] = name;
		expect_known[e.tag] = 1'b1;
		if (e.rd != 5'd0)
			model_regs[e.rd] = c.value;
		sent++;
	endtask

	// Entered and left 1 unit after a rising edge
	task automatic send_instr(input lc_entry_t e, input string name);
		logic taken;
		dispatch_valid = 1'b1;
		dispatch = e;
		taken = 1'b0;
		while (!taken) begin
			@(negedge CLK);
			taken = dispatch_ready;
			@(posedge CLK);
			#1;
		end
		record_dispatch(e, name);
		dispatch_valid = 1'b0;
	endtask

	always @(posedge CLK) begin
		cycles++;
		if (cycles > TIMEOUT)
			fail_run($sformatf("Timeout after %0d cycles with %0d of %0d commits seen",
				cycles, done_count, sent));
	end

	always @(negedge CLK) begin
		if (!rst && commit_valid) begin
			if (!expect_known[commit.tag])
				fail_run($sformatf("Commit for tag %0d which was never dispatched", commit.tag));
			else if (seen[commit.tag])
				fail_run($sformatf("Tag %0d committed a second time", commit.tag));
			else begin
				check_commit(test_of_tag[commit.tag], expected[commit.tag], commit);
				seen[commit.tag] = 1'b1;
				done_count++;
			end
		end
	end

	initial begin
		lc_entry_t e;
		logic [31:0] rnd;
		CLK = 1'b0;
		rst = 1'b1;
		dispatch_valid = 1'b0;
		dispatch = '0;
		rng = 32'h1544393d;
		tag_next = 8'd0;
		for (int r = 0; r < 32; r++)
			model_regs[r] = 64'd0;
		repeat (5) @(posedge CLK);
		#1;
		rst = 1'b0;

		repeat (3) begin
			@(negedge CLK);
			check_flag("reset_state ready", 1'b1, dispatch_ready);
			check_flag("reset_state commit", 1'b0, commit_valid);
		end
		@(posedge CLK);
		#1;

		// Odd registers negative, even ones positive
		for (int r = 1; r < 32; r++) begin
			rng = xorshift32(rng);
			e = '0;
			e.op = OP_ORI;
			e.rd = 5'(r);
			e.src2.imm = {r[0], rng[10:0]};
			e.tag = tag_next;
			tag_next = tag_next + 8'd1;
			send_instr(e, "imm_load");
		end

		for (int n = 0; n < N_MIXED; n++) begin
			rng = xorshift32(rng);
			rnd = rng;
			rng = xorshift32(rng);
			e = '0;
			e.op = lc_op_e'(4'(rnd % 32'd10));
			e.rd = pick_reg(rnd[15:8]);
			e.rs1 = pick_reg(rnd[23:16]);
			if (e.op inside {OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI})
				e.src2.imm = rng[11:0];
			else
				e.src2.reg_idx.idx = pick_reg(rng[7:0]);
			e.tag = tag_next;
			tag_next = tag_next + 8'd1;
			send_instr(e, "mixed_ops");
			if (rng[31:29] == 3'd0) begin
				repeat (int'(rng[28:27]) + 1) begin // Idle gap, otherwise a burst
					@(posedge CLK);
					#1;
				end
			end
		end

		while (done_count < sent)
			@(posedge CLK);
		repeat (10) @(posedge CLK);
		if (done_count == sent) begin
			$display("TEST OK");
			$finish;
		end else begin
			fail_run("More commits arrived than instructions were dispatched");
		end
	end

endmodule

`default_nettype wire

// ==== verif/lc_asserts.sv ====
// Bound into every lc_top with its DEPTH; commits to x0 are exempt from the scoreboard rule
`default_nettype none

module lc_asserts import lc_pkg::*; #(
	parameter int DEPTH = 4
) (
	input  logic CLK,
	input  logic rst,
	input  logic dispatch_valid,
	input  logic dispatch_ready,
	input  logic pop,
	input  logic [31:0] pending,
	input  logic commit_valid,
	input  lc_commit_t commit
);

	int held; // Entries in the buffer, from transfers and pops

	always_ff @(posedge CLK) begin
		if (rst)
			held <= 0;
		else
			held <= held + int'(dispatch_valid && dispatch_ready) - int'(pop);
	end

	// A raised request is held until taken
	valid_held: assert property (@(posedge CLK) disable iff (rst)
		dispatch_valid && !dispatch_ready |=> dispatch_valid)
		else $error("dispatch_valid dropped before the transfer");

	commit_pending: assert property (@(posedge CLK) disable iff (rst)
		commit_valid && commit.rd != 5'd0 |-> pending[commit.rd])
		else $error("commit to a register with no pending writer");

	no_ready_full: assert property (@(posedge CLK) disable iff (rst)
		held == DEPTH |-> !dispatch_ready)
		else $error("dispatch_ready high with every slot occupied");

endmodule

bind lc_top lc_asserts #(
	.DEPTH(DEPTH)
) lc_asserts_inst (
	.CLK(CLK),
	.rst(rst),
	.dispatch_valid(dispatch_valid),
	.dispatch_ready(dispatch_ready),
	.pop(pop),
	.pending(pending),
	.commit_valid(commit_valid),
	.commit(commit)
);

`default_nettype wire

// ==== verilog/lc_top.sv ====
// DEPTH must be at least 2; commit has no back-pressure and must always be accepted
`default_nettype none

module lc_top import lc_pkg::*; #(
	parameter int DEPTH = 4
) (
	input  logic CLK,
	input  logic rst,

	input  logic dispatch_valid,
	input  lc_entry_t dispatch,
	output logic dispatch_ready,

	output logic commit_valid,
	output lc_commit_t commit
);

	localparam int IW = $clog2(DEPTH);

	logic [DEPTH-1:0] occupied;
	lc_entry_t entries [DEPTH];
	logic pop;
	logic [IW-1:0] pop_index;

	logic [31:0] pending;
	logic [4:0] rs1_idx [DEPTH];
	logic [4:0] rs2_idx [DEPTH];
	logic [63:0] rs1_data [DEPTH];
	logic [63:0] rs2_data [DEPTH];

	logic exe_valid;
	lc_exe_t exe;

	logic set_valid;

	assign set_valid = dispatch_valid && dispatch_ready; // Scoreboard marks rd on transfer

	lc_issue_buffer #(
		.DEPTH(DEPTH)
	) lc_issue_buffer_inst (
		.CLK(CLK),
		.rst(rst),
		.dispatch_valid(dispatch_valid),
		.dispatch(dispatch),
		.dispatch_ready(dispatch_ready),
		.pending(pending),
		.pop(pop),
		.pop_index(pop_index),
		.occupied(occupied),
		.entries(entries)
	);

	lc_issue #(
		.DEPTH(DEPTH)
	) lc_issue_inst (
		.CLK(CLK),
		.rst(rst),
		.occupied(occupied),
		.entries(entries),
		.pop(pop),
		.pop_index(pop_index),
		.pending(pending),
		.rs1_idx(rs1_idx),
		.rs2_idx(rs2_idx),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.exe_valid(exe_valid),
		.exe(exe)
	);

	lc_execute lc_execute_inst (
		.CLK(CLK),
		.rst(rst),
		.exe_valid(exe_valid),
		.exe(exe),
		.commit_valid(commit_valid),
		.commit(commit)
	);

	lc_regfile #(
		.DEPTH(DEPTH)
	) lc_regfile_inst (
		.CLK(CLK),
		.rst(rst),
		.rs1_idx(rs1_idx),
		.rs2_idx(rs2_idx),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.set_valid(set_valid),
		.set_rd(dispatch.rd),
		.commit_valid(commit_valid),
		.commit(commit),
		.pending(pending)
	);

endmodule

`default_nettype wire

// ==== verilog/lc_regfile.sv ====
// Reads are combinational; a value written at commit is seen from the following cycle
`default_nettype none

module lc_regfile import lc_pkg::*; #(
	parameter int DEPTH = 4
) (
	input  logic CLK,
	input  logic rst,

	input  logic [4:0] rs1_idx [DEPTH],
	input  logic [4:0] rs2_idx [DEPTH],
	output logic [63:0] rs1_data [DEPTH],
	output logic [63:0] rs2_data [DEPTH],

	input  logic set_valid,
	input  logic [4:0] set_rd,
	input  logic commit_valid,
	input  lc_commit_t commit,

	output logic [31:0] pending
);

	logic [63:0] regs [31:1];

	function automatic logic [63:0] read_reg(logic [4:0] idx);
		if (idx == 5'd0)
			return 64'd0;
		return regs[idx];
	endfunction

	for (genvar i = 0; i < DEPTH; i++) begin : g_read
		assign rs1_data[i] = read_reg(rs1_idx[i]);
		assign rs2_data[i] = read_reg(rs2_idx[i]);
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			for (int r = 1; r < 32; r++)
				regs[r] <= 64'd0;
		end else if (commit_valid && commit.rd != 5'd0) begin
			regs[commit.rd] <= commit.value;
		end
	end

	// Scoreboard
	always_ff @(posedge CLK) begin
		if (rst) begin
			pending <= '0;
		end else begin
			if (commit_valid)
				pending[commit.rd] <= 1'b0;
			// Dispatch stalls on a pending rd, so set and clear never share a bit
			if (set_valid && set_rd != 5'd0)
				pending[set_rd] <= 1'b1;
			pending[0] <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/lc_execute.sv ====
// Single-cycle compute with no stall input; commit is registered and cannot be held back
`default_nettype none

module lc_execute import lc_pkg::*; (
	input  logic CLK,
	input  logic rst,

	input  logic exe_valid,
	input  lc_exe_t exe,

	output logic commit_valid,
	output lc_commit_t commit
);

	logic lt;
	logic [63:0] result;

	assign lt = exe.is_unsigned ? (exe.op1 < exe.op2) :
		($signed(exe.op1) < $signed(exe.op2));

	always_comb begin
		case (exe.fn)
			FN_SLT: result = {63'd0, lt};
			FN_XOR: result = exe.op1 ^ exe.op2;
			FN_OR: result = exe.op1 | exe.op2;
			default: result = exe.op1 & exe.op2; // FN_AND
		endcase
	end

	always_ff @(posedge CLK) begin
		if (rst)
			commit_valid <= 1'b0;
		else
			commit_valid <= exe_valid;
	end

	// Record only moves when there is work
	always_ff @(posedge CLK) begin
		if (exe_valid) begin
			commit.rd <= exe.rd;
			commit.tag <= exe.tag;
			commit.value <= result;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/lc_issue.sv ====
// Execute is assumed always ready, so a ready slot issues in the cycle it is found
`default_nettype none

module lc_issue import lc_pkg::*; #(
	parameter int DEPTH = 4
) (
	input  logic CLK,
	input  logic rst,

	input  logic [DEPTH-1:0] occupied,
	input  lc_entry_t entries [DEPTH],
	output logic pop,
	output logic [$clog2(DEPTH)-1:0] pop_index,

	input  logic [31:0] pending,
	output logic [4:0] rs1_idx [DEPTH],
	output logic [4:0] rs2_idx [DEPTH],
	input  logic [63:0] rs1_data [DEPTH],
	input  logic [63:0] rs2_data [DEPTH],

	output logic exe_valid,
	output lc_exe_t exe
);

	localparam int IW = $clog2(DEPTH);

	logic [DEPTH-1:0] ready;
	lc_exe_t cand [DEPTH];
	logic [IW-1:0] sel;
	logic any_ready;

	function automatic lc_fn_e decode_fn(lc_op_e op);
		case (op)
			OP_SLT, OP_SLTU, OP_SLTI, OP_SLTIU: return FN_SLT;
			OP_XOR, OP_XORI: return FN_XOR;
			OP_OR, OP_ORI: return FN_OR;
			default: return FN_AND;
		endcase
	endfunction

	for (genvar i = 0; i < DEPTH; i++) begin : g_slot
		logic rs1_ok;
		logic rs2_ok;
		logic [63:0] imm64;

		assign rs1_idx[i] = entries[i].rs1;
		assign rs2_idx[i] = entries[i].src2.reg_idx.idx; // Don't care for I forms

		// Source equal to own rd has no older writer left
		assign rs1_ok = rs1_idx[i] == 5'd0 || rs1_idx[i] == entries[i].rd ||
			!pending[rs1_idx[i]];
		assign rs2_ok = !lc_uses_rs2(entries[i].op) || rs2_idx[i] == 5'd0 ||
			rs2_idx[i] == entries[i].rd || !pending[rs2_idx[i]];
		assign ready[i] = occupied[i] && rs1_ok && rs2_ok;

		assign imm64 = {{52{entries[i].src2.imm[11]}}, entries[i].src2.imm};

		always_comb begin
			cand[i].fn = decode_fn(entries[i].op);
			cand[i].is_unsigned = entries[i].op inside {OP_SLTU, OP_SLTIU};
			cand[i].rd = entries[i].rd;
			cand[i].tag = entries[i].tag;
			cand[i].op1 = rs1_data[i];
			cand[i].op2 = lc_is_imm(entries[i].op) ? imm64 : rs2_data[i];
		end
	end

	// Lowest ready slot wins
	always_comb begin
		sel = '0;
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (ready[i])
				sel = IW'(i);
		end
	end

	assign any_ready = |ready;
	assign pop = any_ready;
	assign pop_index = sel;

	always_ff @(posedge CLK) begin
		if (rst)
			exe_valid <= 1'b0;
		else
			exe_valid <= any_ready;
	end

	always_ff @(posedge CLK) begin
		if (any_ready)
			exe <= cand[sel];
	end

endmodule

`default_nettype wire

// ==== verilog/lc_issue_buffer.sv ====
// DEPTH must be at least 2; a slot being popped still counts for the WAR stall in that cycle
`default_nettype none

module lc_issue_buffer import lc_pkg::*; #(
	parameter int DEPTH = 4
) (
	input  logic CLK,
	input  logic rst,

	input  logic dispatch_valid,
	input  lc_entry_t dispatch,
	output logic dispatch_ready,

	input  logic [31:0] pending,

	input  logic pop,
	input  logic [$clog2(DEPTH)-1:0] pop_index,
	output logic [DEPTH-1:0] occupied,
	output lc_entry_t entries [DEPTH]
);

	localparam int IW = $clog2(DEPTH);

	logic [IW-1:0] free_idx;
	logic full;
	logic rd_live;
	logic waw;
	logic war;
	logic push;

	// Lowest free slot
	always_comb begin
		free_idx = '0;
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (!occupied[i])
				free_idx = IW'(i);
		end
	end

	assign full = &occupied;

	// rd still read by a waiting entry
	always_comb begin
		war = 1'b0;
		for (int i = 0; i < DEPTH; i++) begin
			if (occupied[i] && entries[i].rs1 == dispatch.rd)
				war = 1'b1;
			if (occupied[i] && lc_uses_rs2(entries[i].op) &&
					entries[i].src2.reg_idx.idx == dispatch.rd)
				war = 1'b1;
		end
	end

	assign rd_live = dispatch.rd != 5'd0;
	assign waw = pending[dispatch.rd]; // Older writer not yet committed

	assign dispatch_ready = !full && !(rd_live && (waw || war));
	assign push = dispatch_valid && dispatch_ready;

	always_ff @(posedge CLK) begin
		if (rst) begin
			occupied <= '0;
		end else begin
			// Pop and push never hit the same slot
			if (pop)
				occupied[pop_index] <= 1'b0;
			if (push)
				occupied[free_idx] <= 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (push)
			entries[free_idx] <= dispatch;
	end

endmodule

`default_nettype wire

// ==== verilog/lc_pkg.sv ====
// Covers only the ten RV64I logic and compare ops; x0 is hard zero and tags are 8 bits that wrap
`default_nettype none

package lc_pkg;

	typedef enum logic [3:0] {
		OP_SLT,
		OP_SLTU,
		OP_SLTI,
		OP_SLTIU,
		OP_XOR,
		OP_XORI,
		OP_OR,
		OP_ORI,
		OP_AND,
		OP_ANDI
	} lc_op_e;

	// Execute function select
	typedef enum logic [1:0] {
		FN_SLT,
		FN_XOR,
		FN_OR,
		FN_AND
	} lc_fn_e;

	typedef struct packed {
		logic [6:0] pad;
		logic [4:0] idx;
	} lc_reg_src_t;

	// Second operand field, meaning set by the opcode
	typedef union packed {
		logic signed [11:0] imm; // I forms
		lc_reg_src_t reg_idx; // R forms
	} lc_src2_u;

	typedef struct packed {
		lc_op_e op;
		logic [4:0] rd;
		logic [4:0] rs1;
		lc_src2_u src2;
		logic [7:0] tag;
	} lc_entry_t;

	typedef struct packed {
		lc_fn_e fn;
		logic is_unsigned;
		logic [4:0] rd;
		logic [7:0] tag;
		logic [63:0] op1;
		logic [63:0] op2;
	} lc_exe_t;

	typedef struct packed {
		logic [4:0] rd;
		logic [7:0] tag;
		logic [63:0] value;
	} lc_commit_t;

	function automatic logic lc_is_imm(lc_op_e op);
		return op inside {OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI};
	endfunction

	function automatic logic lc_uses_rs2(lc_op_e op);
		return !lc_is_imm(op);
	endfunction

endpackage

`default_nettype wire
